// File: common/adc_cfg_pkg.sv
package adc_cfg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// SPI frame layout of the LTC2195

	localparam int FRAME_BITS = 16;	// Bits per SPI transfer

	typedef struct packed {
		logic       rw;	// 0 = write, read-back not supported
		logic [6:0] reg_addr;
		logic [7:0] reg_data;
	} spi_frame_t;

	////////////////////////////////////////////////////////////////////////////
	// Host command and pin bundles

	typedef struct packed {
		logic        strobe;	// One-cycle command strobe
		logic [15:0] addr;	// Upper byte selects the command
		logic [15:0] data;	// Only the low byte reaches the ADC
	} cfg_cmd_t;

	typedef struct packed {
		logic scs0;	// Chip select ADC0, active low
		logic scs1;	// Chip select ADC1, active low
		logic sck;
		logic sdo;
	} spi_pins_t;

	typedef enum logic [3:0] {
		ST_STARTUP,	// Power-up wait
		ST_LOAD,	// Wait for ready, latch next frame
		ST_PULSE,	// Trigger high
		ST_RELEASE,	// Trigger low again
		ST_IDLE	// Waiting for host writes
	} seq_state_t;

	localparam logic [7:0] WRITE_PREFIX = 8'h31;	// addr[15:8] of a host write

	// Soft reset, two's complement format, two-lane output
	localparam int INIT_COUNT = 3;
	localparam spi_frame_t INIT_FRAMES [INIT_COUNT] = '{
		'{rw: 1'b0, reg_addr: 7'h00, reg_data: 8'h80},
		'{rw: 1'b0, reg_addr: 7'h01, reg_data: 8'h20},
		'{rw: 1'b0, reg_addr: 7'h02, reg_data: 8'h00}
	};

endpackage

// File: spi/spi_bit_timer.sv
module spi_bit_timer #(
	parameter int SPI_CLK_DIV = 10	// hz_clk cycles per SCK half period
) (
	input  logic hz_clk,
	input  logic rst_in,
	input  logic run,	// Frame active
	output logic sck,	// SPI clock, idles low
	output logic shift,	// One cycle, on each falling edge
	output logic last_bit	// One cycle, falling edge after the 16th rise
);

	localparam int DIV_W = $clog2(SPI_CLK_DIV + 1);
	localparam int BIT_W = $clog2(adc_cfg_pkg::FRAME_BITS + 1);

	logic [DIV_W-1:0] div_cnt;	// Half-period divider
	logic [BIT_W-1:0] bit_cnt;	// Rising edges so far
	logic             half_done;	// Divider at terminal count

	assign half_done = (div_cnt == DIV_W'(SPI_CLK_DIV - 1));

	////////////////////////////////////////////////////////////////////////////
	// Divider and bit counter

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			div_cnt  <= '0;
			bit_cnt  <= '0;
			sck      <= 1'b0;
			shift    <= 1'b0;
			last_bit <= 1'b0;
		end else if (!run) begin
			// Everything parked between frames
			div_cnt  <= '0;
			bit_cnt  <= '0;
			sck      <= 1'b0;
			shift    <= 1'b0;
			last_bit <= 1'b0;
		end else begin
			shift    <= 1'b0;
			last_bit <= 1'b0;
			if (half_done) begin
				div_cnt <= '0;
				sck     <= ~sck;
				if (!sck) begin
					bit_cnt <= bit_cnt + BIT_W'(1);	// Rising edge, ADC samples sdo
				end else begin
					shift <= 1'b1;	// Falling edge, next bit out
					if (bit_cnt == BIT_W'(adc_cfg_pkg::FRAME_BITS))
						last_bit <= 1'b1;
				end
			end else begin
				div_cnt <= div_cnt + DIV_W'(1);
			end
		end
	end

endmodule

// File: spi/spi_shifter.sv
module spi_shifter #(
	parameter int SPI_CLK_DIV = 10
) (
	input  logic                    hz_clk,
	input  logic                    rst_in,
	input  logic                    trigger,	// Start, only honoured while ready
	input  adc_cfg_pkg::spi_frame_t frame,
	output logic                    ready,	// Low from trigger until CS rises
	output adc_cfg_pkg::spi_pins_t  spi
);

	localparam int TAIL_W = $clog2(SPI_CLK_DIV + 1);

	logic [adc_cfg_pkg::FRAME_BITS-1:0] shreg;	// MSB drives sdo
	logic              cs_n;	// Shared by both ADCs
	logic              run;	// Enables the bit timer
	logic              tail;	// Waiting the last half period
	logic [TAIL_W-1:0] tail_cnt;
	logic              sck;
	logic              shift;
	logic              last_bit;

	spi_bit_timer #(
		.SPI_CLK_DIV(SPI_CLK_DIV)
	) i_bit_timer (
		.hz_clk   (hz_clk),
		.rst_in   (rst_in),
		.run      (run),
		.sck      (sck),
		.shift    (shift),
		.last_bit (last_bit)
	);

	////////////////////////////////////////////////////////////////////////////
	// Frame control and shift register

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			shreg    <= '0;	// Keeps sdo low out of reset
			cs_n     <= 1'b1;
			run      <= 1'b0;
			ready    <= 1'b1;
			tail     <= 1'b0;
			tail_cnt <= '0;
		end else begin
			if (trigger && ready) begin
				shreg <= frame;
				cs_n  <= 1'b0;	// Both ADCs selected
				run   <= 1'b1;
				ready <= 1'b0;
			end else if (shift) begin
				shreg <= {shreg[adc_cfg_pkg::FRAME_BITS-2:0], 1'b0};	// Zeros fill in
			end
			if (last_bit) begin
				run      <= 1'b0;	// sck already low here
				tail     <= 1'b1;
				tail_cnt <= TAIL_W'(1);	// One cycle since the falling edge
			end else if (tail) begin
				// CS release a half period after the last falling edge
				if (tail_cnt >= TAIL_W'(SPI_CLK_DIV - 1)) begin
					cs_n  <= 1'b1;
					ready <= 1'b1;
					tail  <= 1'b0;
				end else begin
					tail_cnt <= tail_cnt + TAIL_W'(1);
				end
			end
		end
	end

	assign spi.scs0 = cs_n;
	assign spi.scs1 = cs_n;	// Chip selects toggle together
	assign spi.sck  = sck;
	assign spi.sdo  = shreg[adc_cfg_pkg::FRAME_BITS-1];

endmodule

// File: verilog/cfg_sequencer.sv
module cfg_sequencer #(
	parameter int STARTUP_CYCLES = 255
) (
	input  logic                    hz_clk,
	input  logic                    rst_in,
	input  adc_cfg_pkg::cfg_cmd_t   cmd,
	input  logic                    ready,	// SPI master idle
	output logic                    trigger,	// Start one SPI frame
	output adc_cfg_pkg::spi_frame_t frame	// Frame for the SPI master
);

	localparam int START_W = $clog2(STARTUP_CYCLES + 1);
	localparam int IDX_W   = $clog2(adc_cfg_pkg::INIT_COUNT + 1);

	adc_cfg_pkg::seq_state_t state;
	logic [START_W-1:0]      start_cnt;	// Start-up down-counter
	logic [IDX_W-1:0]        init_idx;	// Next init frame to send
	logic                    host_pending;	// Host write waiting in ST_LOAD
	adc_cfg_pkg::spi_frame_t host_frame;	// Frame built from the host command
	logic                    cmd_write;	// Strobe with the write prefix
	logic                    init_left;	// Init frames still to go

	assign cmd_write = cmd.strobe && (cmd.addr[15:8] == adc_cfg_pkg::WRITE_PREFIX);
	assign init_left = init_idx < IDX_W'(adc_cfg_pkg::INIT_COUNT);

	////////////////////////////////////////////////////////////////////////////
	// Control FSM

	always_ff @(posedge hz_clk or posedge rst_in) begin
		if (rst_in) begin
			state        <= adc_cfg_pkg::ST_STARTUP;
			start_cnt    <= START_W'(STARTUP_CYCLES);
			init_idx     <= '0;
			host_pending <= 1'b0;
			trigger      <= 1'b0;
		end else begin
			case (state)
				adc_cfg_pkg::ST_STARTUP: begin
					// ADC needs time after power-up before it takes writes
					if (start_cnt <= START_W'(1))
						state <= adc_cfg_pkg::ST_LOAD;
					else
						start_cnt <= start_cnt - START_W'(1);
				end
				adc_cfg_pkg::ST_LOAD: begin
					if (ready) begin	// Previous frame done, frame reg free
						if (init_left || host_pending) begin
							trigger <= 1'b1;
							state   <= adc_cfg_pkg::ST_PULSE;
							if (init_left)
								init_idx <= init_idx + IDX_W'(1);
							else
								host_pending <= 1'b0;
						end else begin
							state <= adc_cfg_pkg::ST_IDLE;	// Nothing left to send
						end
					end
				end
				adc_cfg_pkg::ST_PULSE: begin
					trigger <= 1'b0;	// Single-cycle trigger
					state   <= adc_cfg_pkg::ST_RELEASE;
				end
				adc_cfg_pkg::ST_RELEASE: begin
					state <= adc_cfg_pkg::ST_LOAD;	// Wait there for the frame to finish
				end
				adc_cfg_pkg::ST_IDLE: begin
					// Strobes outside idle are dropped
					if (cmd_write) begin
						host_pending <= 1'b1;
						state        <= adc_cfg_pkg::ST_LOAD;
					end
				end
				default: state <= adc_cfg_pkg::ST_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Frame registers

	always_ff @(posedge hz_clk) begin
		if (state == adc_cfg_pkg::ST_IDLE && cmd_write) begin
			host_frame.rw       <= 1'b0;	// Write only
			host_frame.reg_addr <= cmd.addr[6:0];
			host_frame.reg_data <= cmd.data[7:0];
		end
		// Latched together with the trigger, stays put while in flight
		if (state == adc_cfg_pkg::ST_LOAD && ready && (init_left || host_pending)) begin
			if (init_left)
				frame <= adc_cfg_pkg::INIT_FRAMES[init_idx];
			else
				frame <= host_frame;
		end
	end

endmodule

// File: verilog/adc_cfg_top.sv
module adc_cfg_top #(
	parameter int SPI_CLK_DIV    = 10,	// hz_clk cycles per SCK half period
	parameter int STARTUP_CYCLES = 255	// Wait after reset before the init writes
) (
	input  logic                   hz_clk,
	input  logic                   rst_in,
	input  adc_cfg_pkg::cfg_cmd_t  cmd,	// Host command, strobe is one cycle
	output adc_cfg_pkg::spi_pins_t spi	// Shared SCK/SDO, two chip selects
);

	////////////////////////////////////////////////////////////////////////////
	// Sequencer to SPI master

	logic                    trigger;	// One-cycle start pulse
	logic                    ready;	// High while no frame is in flight
	adc_cfg_pkg::spi_frame_t frame;	// Held until ready returns

	// Start-up wait, init writes and host writes
	cfg_sequencer #(
		.STARTUP_CYCLES(STARTUP_CYCLES)
	) i_sequencer (
		.hz_clk  (hz_clk),
		.rst_in  (rst_in),
		.cmd     (cmd),
		.ready   (ready),
		.trigger (trigger),
		.frame   (frame)
	);

	// 16-bit write-only SPI master
	spi_shifter #(
		.SPI_CLK_DIV(SPI_CLK_DIV)
	) i_shifter (
		.hz_clk  (hz_clk),
		.rst_in  (rst_in),
		.trigger (trigger),
		.frame   (frame),
		.ready   (ready),
		.spi     (spi)
	);

endmodule

// File: verification/tb_clock_gen.sv
module tb_clock_gen #(
	parameter int PERIOD = 40	// Time units per hz_clk cycle
) (
	output logic hz_clk
);

	initial begin
		hz_clk = 1'b0;
		forever #(PERIOD / 2) hz_clk = ~hz_clk;	// 50 % duty
	end

endmodule

// File: verification/adc_cfg_assertions.sv
module adc_cfg_assertions (
	input logic                   hz_clk,
	input logic                   rst_in,
	input adc_cfg_pkg::spi_pins_t spi
);

	int cs_fails  = 0;	// Failure tallies, read by the testbench
	int sck_fails = 0;
	int sdo_fails = 0;
	int fail_count;

	assign fail_count = cs_fails + sck_fails + sdo_fails;

	////////////////////////////////////////////////////////////////////////////
	// SPI pin protocol

	// Both ADCs are always selected together
	a_cs_match: assert property (@(posedge hz_clk) disable iff (rst_in)
		spi.scs0 == spi.scs1)
		else begin
			$error("scs0 and scs1 differ");
			cs_fails++;
		end

	a_sck_parked: assert property (@(posedge hz_clk) disable iff (rst_in)
		spi.scs0 |-> !spi.sck)	// No clock outside a frame
		else begin
			$error("sck high while chip select is high");
			sck_fails++;
		end

	// ADC samples sdo on the rising edge
	a_sdo_setup: assert property (@(posedge hz_clk) disable iff (rst_in)
		$rose(spi.sck) |-> $stable(spi.sdo))
		else begin
			$error("sdo changed at a rising edge of sck");
			sdo_fails++;
		end

endmodule

bind adc_cfg_top adc_cfg_assertions i_assertions (
	.hz_clk (hz_clk),
	.rst_in (rst_in),
	.spi    (spi)
);

// File: verification/tb_adc_cfg.sv
module tb_adc_cfg;

	localparam int SPI_CLK_DIV    = 2;
	localparam int STARTUP_CYCLES = 20;
	localparam int RESET_CYCLES   = 16;
	localparam int DRIVE_DELAY    = 2;	// Input skew after the rising edge
	localparam int NUM_CMDS       = 24;
	localparam int FRAME_TIMEOUT  = 200;	// A frame takes about 70 cycles here
	localparam int CS_TIMEOUT     = 16;
	localparam int IGNORE_CYCLES  = 200;
	localparam int CS_GAP         = 6;	// CS high time before a new command
	localparam logic [7:0] WRITE_PREFIX = 8'h31;

	logic                   hz_clk;
	logic                   rst_in;
	adc_cfg_pkg::cfg_cmd_t  cmd;
	adc_cfg_pkg::spi_pins_t spi;
	int                     seed;
	logic [15:0]            exp_q[$];	// Model, frames still expected
	logic [15:0]            rx_q[$];	// Frames seen on the pins

	logic [15:0] rx_shift;	// Slave monitor state
	int          rx_bits;
	logic        prev_sck;
	logic        prev_cs;

	tb_clock_gen #(.PERIOD(40)) i_clock_gen (.hz_clk(hz_clk));

	adc_cfg_top #(
		.SPI_CLK_DIV    (SPI_CLK_DIV),
		.STARTUP_CYCLES (STARTUP_CYCLES)
	) i_dut (
		.hz_clk (hz_clk),
		.rst_in (rst_in),
		.cmd    (cmd),
		.spi    (spi)
	);

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting and waits

	task automatic fail_run(input string reason);
		$display("%s (time %0t)", reason, $time);
		$display("Simulation failed");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, name, actual, expected);
			fail_run("Value mismatch");
		end
	endtask

	task automatic next_cycle();
		@(posedge hz_clk);
		#DRIVE_DELAY;	// Outputs settled, inputs change here
	endtask

	task automatic check_idle_pins();
		check_value("spi.scs0", 32'(spi.scs0), 32'(1'b1));
		check_value("spi.scs1", 32'(spi.scs1), 32'(1'b1));
		check_value("spi.sck", 32'(spi.sck), 32'(1'b0));
		check_value("spi.sdo", 32'(spi.sdo), 32'(1'b0));
	endtask

	task automatic wait_frames(input int count, input int limit, input string what);
		int waited;
		waited = 0;
		while (rx_q.size() < count) begin
			if (waited >= limit)
				fail_run($sformatf("Timed out waiting for %s", what));
			next_cycle();
			waited++;
		end
	endtask

	task automatic wait_cs_low();
		int waited;
		waited = 0;
		while (spi.scs0) begin
			if (waited >= CS_TIMEOUT)
				fail_run("Timed out waiting for chip select to fall after a write command");
			next_cycle();
			waited++;
		end
	endtask

	task automatic wait_cs_high_for(input int cycles);
		int high_run;
		int waited;
		high_run = 0;
		waited   = 0;
		while (high_run < cycles) begin
			if (waited >= FRAME_TIMEOUT)
				fail_run("Timed out waiting for chip select to stay high between frames");
			next_cycle();
			waited++;
			if (spi.scs0)
				high_run++;
			else
				high_run = 0;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// SPI slave monitor, samples away from the active clock edge

	always @(negedge hz_clk) begin
		if (rst_in) begin
			prev_sck = 1'b0;
			prev_cs  = 1'b1;
			rx_bits  = 0;
		end else begin
			if (!spi.scs0 && prev_cs)
				rx_bits = 0;	// New frame
			if (!spi.scs0 && spi.sck && !prev_sck) begin
				rx_shift = {rx_shift[14:0], spi.sdo};	// MSB first
				rx_bits++;
			end
			if (spi.scs0 && !prev_cs) begin
				check_value("frame bit count", rx_bits, 32'd16);
				rx_q.push_back(rx_shift);
			end
			prev_sck = spi.sck;
			prev_cs  = spi.scs0;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus and model

	task automatic compare_frames();
		logic [15:0] got;
		logic [15:0] want;
		while (rx_q.size() > 0) begin
			got = rx_q.pop_front();
			if (exp_q.size() == 0)
				fail_run($sformatf("Frame 0x%04h was sent but none was expected", got));
			want = exp_q.pop_front();
			check_value("spi frame", 32'(got), 32'(want));
		end
	endtask

	task automatic pulse_command(input logic [15:0] addr, input logic [15:0] data);
		cmd.strobe = 1'b1;
		cmd.addr   = addr;
		cmd.data   = data;
		next_cycle();	// Strobe lasts one cycle
		cmd = '0;
	endtask

	task automatic send_write_command();
		logic [31:0] r;
		logic [15:0] addr;
		logic [15:0] data;
		r    = $random(seed);
		addr = {WRITE_PREFIX, r[7:0]};
		data = r[31:16];
		wait_cs_high_for(CS_GAP);
		exp_q.push_back({1'b0, addr[6:0], data[7:0]});	// Write, 7-bit reg, low data byte
		pulse_command(addr, data);
		wait_cs_low();
		r = $random(seed);
		pulse_command({WRITE_PREFIX, r[7:0]}, r[31:16]);	// Busy, must be dropped
		wait_frames(1, FRAME_TIMEOUT, "the frame of a host write");
		compare_frames();
	endtask

	task automatic send_other_command();
		logic [31:0] r;
		logic [7:0]  prefix;
		r      = $random(seed);
		prefix = r[15:8];
		if (prefix == WRITE_PREFIX)
			prefix = prefix ^ 8'h01;
		wait_cs_high_for(CS_GAP);
		pulse_command({prefix, r[7:0]}, r[31:16]);
		repeat (IGNORE_CYCLES) begin
			next_cycle();
			check_value("spi.scs0", 32'(spi.scs0), 32'(1'b1));	// No frame may start
		end
		check_value("frames after other command", rx_q.size(), 32'd0);
	endtask

	initial begin
		logic [31:0] pick;
		seed   = 11621;
		rst_in = 1'b1;
		cmd    = '0;
		exp_q.push_back(16'h0080);	// Soft reset
		exp_q.push_back(16'h0120);	// Two's complement
		exp_q.push_back(16'h0200);	// Two-lane output
		repeat (RESET_CYCLES) begin
			next_cycle();
			check_idle_pins();
		end
		rst_in = 1'b0;
		repeat (STARTUP_CYCLES - 2) begin
			next_cycle();
			check_idle_pins();	// Still in the start-up wait
		end
		wait_frames(3, 3 * FRAME_TIMEOUT, "the three init frames");
		compare_frames();
		for (int n = 0; n < NUM_CMDS; n++) begin
			pick = $random(seed);
			if (pick[1:0] != 2'b00)
				send_write_command();
			else
				send_other_command();
		end
		wait_cs_high_for(CS_GAP);
		check_value("frames not checked", rx_q.size(), 32'd0);
		if (i_dut.i_assertions.fail_count == 0) begin
			$display("Simulation passed");
			$finish;
		end else begin
			$display("Simulation failed");
			$fatal(1, "Protocol assertions reported errors");
		end
	end

endmodule

// File: compile.f
common/adc_cfg_pkg.sv
spi/spi_bit_timer.sv
spi/spi_shifter.sv
verilog/cfg_sequencer.sv
verilog/adc_cfg_top.sv
verification/tb_clock_gen.sv
verification/adc_cfg_assertions.sv
verification/tb_adc_cfg.sv

// File: Makefile
# Verilator flow for the ADC configuration path

VERILATOR  ?= verilator
TOP        ?= tb_adc_cfg
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Simulation passed
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Run did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
